// File: dv/pre_if_checker.sv
`timescale 1ns/1ps

module pre_if_checker (
    input logic                     clk,
    input logic                     reset,
    input logic                     flush,
    input logic                     icache_busy,
    input logic                     tlb_stall,
    input mips_cp0_pkg::vaddr_t     pc,
    input fetch_bus_pkg::ps_to_fs_t ps_to_fs
);
    import mips_cp0_pkg::*;

    // count of failed assertions
    int assert_fails = 0;

    // busy cache without a flush keeps the pc where it is
    pc_hold_on_busy: assert property (@(posedge clk) disable iff (reset)
        (icache_busy && !flush) |=> $stable(pc))
        else begin
            assert_fails++;
            $error("pc moved while icache_busy was high without flush");
        end

    ex_has_code: assert property (@(posedge clk) disable iff (reset)
        ps_to_fs.ex |-> (ps_to_fs.exctype != EXC_NONE))
        else begin
            assert_fails++;
            $error("ps_to_fs.ex set with exctype EXC_NONE");
        end

    // a stalled lookup has no translation yet
    no_valid_in_stall: assert property (@(posedge clk) disable iff (reset)
        !(ps_to_fs.inst_valid && tlb_stall))
        else begin
            assert_fails++;
            $error("inst_valid asserted during a tlb stall");
        end

endmodule

bind fetch_request pre_if_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .icache_busy (icache_busy),
    .tlb_stall   (tlb_stall),
    .pc          (pc),
    .ps_to_fs    (ps_to_fs)
);

// File: dv/pre_if_golden.txt
# map: vpn(even) found even_pfn even_v odd_pfn odd_v
# test: name cycles ctrl bpu_tgt br_tgt br_es_pc exc_addr epc/refetch_pc cidx, then pc idx tag off v iv ex code
map 00400 1 12345 1 0abcd 1
map 00402 1 22222 0 33333 1
rst_hold 1 0000 00000000 00000000 00000000 00000000 00000000 00 bfc00000 00 1fc00 0 0 0 0 31
seq_pc4 2 0004 00000000 00000000 00000000 00000000 00000000 00 bfc00008 00 1fc00 8 1 1 0 31
bpu_tgt 1 0804 bfc00100 00000000 00000000 00000000 00000000 00 bfc00100 10 1fc00 0 1 1 0 31
mis_tkn 1 0704 00000000 bfc00200 bfc00300 00000000 00000000 00 bfc00200 20 1fc00 0 1 1 0 31
mis_ntk 1 0604 00000000 bfc00200 bfc00300 00000000 00000000 00 bfc00308 30 1fc00 8 1 1 0 31
unp_tkn 1 0304 00000000 bfc00400 bfc00300 00000000 00000000 00 bfc00400 40 1fc00 0 1 1 0 31
eret_pri 1 0354 00000000 bfc00400 bfc00300 bfc00500 bfc00600 00 bfc00600 60 1fc00 0 1 1 0 31
flsh_pri 1 0344 00000000 bfc00400 bfc00300 bfc00700 bfc00600 00 bfc00700 70 1fc00 0 1 1 0 31
refetch 1 004c 00000000 00000000 00000000 bfc00700 bfc00800 00 bfc00800 80 1fc00 0 1 1 0 31
flsh_bsy 1 0042 00000000 00000000 00000000 bfc00900 00000000 00 bfc00900 90 1fc00 0 1 0 0 31
hold_bsy 2 0006 00000000 00000000 00000000 00000000 00000000 00 bfc00900 90 1fc00 0 0 0 0 31
resume 1 0004 00000000 00000000 00000000 00000000 00000000 00 bfc00904 90 1fc00 4 1 1 0 31
adel 1 0014 00000000 00000000 00000000 00000000 bfc00a02 00 bfc00a02 a0 1fc00 2 0 0 1 04
adel_msk 1 0034 00000000 00000000 00000000 00000000 bfc00a02 00 bfc00a02 a0 1fc00 2 1 0 0 31
map_even 2 0014 00000000 00000000 00000000 00000000 00400000 00 00400000 00 12345 0 1 1 0 31
same_pg 1 0004 00000000 00000000 00000000 00000000 00000000 00 00400004 00 12345 4 1 1 0 31
odd_stl 1 0014 00000000 00000000 00000000 00000000 00401000 00 00401000 00 12345 0 0 0 0 31
odd_hit 1 0014 00000000 00000000 00000000 00000000 00401000 00 00401000 00 0abcd 0 1 1 0 31
tlb_fl 1 0005 00000000 00000000 00000000 00000000 00000000 00 00401004 00 0abcd 4 0 0 0 31
refill 1 0004 00000000 00000000 00000000 00000000 00000000 00 00401004 00 0abcd 4 1 1 0 31
tlb_inv 2 0014 00000000 00000000 00000000 00000000 00402000 00 00402000 00 22222 0 0 0 1 02
tlb_miss 2 0014 00000000 00000000 00000000 00000000 00800000 00 00800000 00 00000 0 0 0 1 02
miss_msk 1 0034 00000000 00000000 00000000 00000000 00800000 00 00800000 00 00000 0 1 0 0 31
cinst_pc 1 0014 00000000 00000000 00000000 00000000 bfc00040 00 bfc00040 04 1fc00 0 1 1 0 31
cinst 1 1006 00000000 00000000 00000000 00000000 00000000 5a bfc00040 5a 1fc00 0 0 0 0 31
cinst_bsy 1 0006 00000000 00000000 00000000 00000000 00000000 5a bfc00040 5a 1fc00 0 0 0 0 31
cinst_end 1 0004 00000000 00000000 00000000 00000000 00000000 00 bfc00044 04 1fc00 4 1 1 0 31

// File: dv/pre_if_tb.sv
`timescale 1ns/1ps

module pre_if_tb;
    import mips_cp0_pkg::*;
    import fetch_bus_pkg::*;

    logic clk;
    logic reset;
    logic flush, br_flush, eret, refetch;
    logic fs_allowin, icache_busy, tlb_flush, cache_inst_strobe;
    vaddr_t exc_addr, epc, refetch_pc, prefs_pc;
    cache_index_t cache_index;
    bpu_bus_t bpu;
    br_bus_t br;
    vpn_t tlb_vpn;
    tlb_resp_t tlb_resp;
    icache_req_t icache_req;
    ps_to_fs_t ps_to_fs;

    // test table from the golden file
    string t_name[$];
    int t_cycles[$];
    logic [15:0] t_ctrl[$];
    vaddr_t t_bpu[$], t_br_target[$], t_es_pc[$], t_exc[$], t_alt[$];
    cache_index_t t_cidx[$];
    vaddr_t exp_pc[$];
    icache_req_t exp_req[$];
    ps_to_fs_t exp_ps[$];

    // main TLB contents
    vpn_t map_vpn[8];
    tlb_resp_t map_resp[8];
    int map_count = 0;

    logic loaded = 1'b0;
    int test_errs, pass_count, fail_count, bad_lines;

    pre_if_top UUT (.*);

    always #5 clk = ~clk;

    // a map entry answers for both pages of its pair
    function automatic tlb_resp_t lookup_tlb(vpn_t vpn);
        tlb_resp_t resp;
        resp = '0;
        for (int k = 0; k < 8; k++) begin
            if (k < map_count && map_vpn[k][19:1] == vpn[19:1]) begin
                resp = map_resp[k];
            end
        end
        return resp;
    endfunction

    assign tlb_resp = lookup_tlb(tlb_vpn);

    task automatic read_golden();
        int fd, n, cyc, code;
        string line, key, nm;
        logic [15:0] ctrl;
        logic [31:0] bt, brt, esp, exc, alt, xpc;
        logic [19:0] m_vpn, m_epfn, m_opfn, xtag;
        logic [7:0] cidx, xidx;
        logic [3:0] xoff;
        logic m_found, m_ev, m_ov, xv, xiv, xex;
        tlb_resp_t resp;
        icache_req_t req;
        ps_to_fs_t ps;
        fd = $fopen("dv/pre_if_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file dv/pre_if_golden.txt");
            bad_lines++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s", key);
            if (n == 1 && key == "map") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h", key, m_vpn, m_found,
                            m_epfn, m_ev, m_opfn, m_ov);
                resp = '0;
                resp.found = m_found;
                resp.even.pfn = m_epfn;
                resp.even.v = m_ev;
                resp.odd.pfn = m_opfn;
                resp.odd.v = m_ov;
                map_vpn[map_count] = m_vpn;
                map_resp[map_count] = resp;
                map_count++;
            end else if (n == 1 && key.substr(0, 0) != "#") begin
                n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                            nm, cyc, ctrl, bt, brt, esp, exc, alt, cidx,
                            xpc, xidx, xtag, xoff, xv, xiv, xex, code);
                if (n != 17) begin
                    $display("golden file line could not be parsed: %s", line);
                    bad_lines++;
                end else begin
                    req.index = xidx;
                    req.tag = xtag;
                    req.offset = xoff;
                    req.valid = xv;
                    ps.inst_valid = xiv;
                    ps.pc = xpc;
                    ps.ex = xex;
                    ps.exctype = exc_code_t'(code);
                    t_name.push_back(nm);
                    t_cycles.push_back(cyc);
                    t_ctrl.push_back(ctrl);
                    t_bpu.push_back(bt);
                    t_br_target.push_back(brt);
                    t_es_pc.push_back(esp);
                    t_exc.push_back(exc);
                    t_alt.push_back(alt);
                    t_cidx.push_back(cidx);
                    exp_pc.push_back(xpc);
                    exp_req.push_back(req);
                    exp_ps.push_back(ps);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_inputs(int i);
        logic [15:0] c;
        c = t_ctrl[i];
        cache_inst_strobe = c[12];
        bpu.valid = c[11];
        bpu.target = t_bpu[i];
        br.br_bpu_valid = c[10];
        br.is_branch = c[9];
        br.br_taken = c[8];
        br.br_bpu_right = c[7];
        br.br_target = t_br_target[i];
        br.br_es_pc = t_es_pc[i];
        flush = c[6];
        br_flush = c[5];
        eret = c[4];
        refetch = c[3];
        fs_allowin = c[2];
        icache_busy = c[1];
        tlb_flush = c[0];
        exc_addr = t_exc[i];
        epc = t_alt[i];
        refetch_pc = t_alt[i];
        cache_index = t_cidx[i];
    endtask

    task automatic compare_pc(string name, vaddr_t exp, vaddr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s prefs_pc expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic compare_vpn(string name, vpn_t exp, vpn_t act);
        if (act !== exp) begin
            $display("MISMATCH %s tlb_vpn expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic compare_req(string name, icache_req_t exp, icache_req_t act);
        if (act !== exp) begin
            $display("MISMATCH %s icache_req expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic compare_ps(string name, ps_to_fs_t exp, ps_to_fs_t act);
        if (act !== exp) begin
            $display("MISMATCH %s ps_to_fs expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        bpu = '0;
        br = '0;
        {flush, br_flush, eret, refetch} = 4'b0000;
        {fs_allowin, icache_busy, tlb_flush, cache_inst_strobe} = 4'b0000;
        exc_addr = '0;
        epc = '0;
        refetch_pc = '0;
        cache_index = '0;
        pass_count = 0;
        fail_count = 0;
        bad_lines = 0;
        read_golden();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < t_name.size(); i++) begin
            apply_inputs(i);
            repeat (t_cycles[i]) @(posedge clk);
            #1;
            test_errs = 0;
            compare_pc(t_name[i], exp_pc[i], prefs_pc);
            // the main TLB is asked for the page of the fetch pc
            compare_vpn(t_name[i], exp_pc[i][31:12], tlb_vpn);
            compare_req(t_name[i], exp_req[i], icache_req);
            compare_ps(t_name[i], exp_ps[i], ps_to_fs);
            if (test_errs == 0) begin
                pass_count++;
                $display("test %s ok", t_name[i]);
            end else begin
                fail_count++;
                $display("test %s failed", t_name[i]);
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d bad golden lines, %0d assertion errors",
                 t_name.size(), pass_count, fail_count, bad_lines,
                 UUT.u_fetch_req.u_checker.assert_fails);
        if (fail_count == 0 && bad_lines == 0 && t_name.size() > 0 &&
            UUT.u_fetch_req.u_checker.assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // 20 cycles per golden line plus the reset time
    initial begin
        wait (loaded);
        repeat ((t_name.size() + map_count) * 20 + 16) @(posedge clk);
        $display("timeout: the test sequence did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: pre_if_front.f
rtl/mips_cp0_pkg.sv
rtl/fetch_bus_pkg.sv
rtl/next_pc_decode.sv
rtl/itlb_translate.sv
rtl/fetch_request.sv
rtl/pre_if_top.sv
dv/pre_if_checker.sv
dv/pre_if_tb.sv

// File: rtl/fetch_bus_pkg.sv
package fetch_bus_pkg;

    // branch predictor target for the pre-fetch stage
    typedef struct packed {
        mips_cp0_pkg::vaddr_t target;
        logic                 valid;
    } bpu_bus_t;

    // branch resolution from execute
    typedef struct packed {
        logic                 br_bpu_valid;
        logic                 is_branch;
        logic                 br_taken;
        logic                 br_bpu_right;
        mips_cp0_pkg::vaddr_t br_target;
        mips_cp0_pkg::vaddr_t br_es_pc;
    } br_bus_t;

    // one page of a TLB pair
    typedef struct packed {
        mips_cp0_pkg::pfn_t pfn;
        logic [2:0]         c;
        logic               d;
        logic               v;
    } tlb_entry_t;

    // main TLB answer, even page first
    typedef struct packed {
        logic       found;
        tlb_entry_t even;
        tlb_entry_t odd;
    } tlb_resp_t;

    typedef struct packed {
        mips_cp0_pkg::cache_index_t index;
        mips_cp0_pkg::pfn_t         tag;
        logic [3:0]                 offset;
        logic                       valid;
    } icache_req_t;

    typedef struct packed {
        logic                    inst_valid;
        mips_cp0_pkg::vaddr_t    pc;
        logic                    ex;
        mips_cp0_pkg::exc_code_t exctype;
    } ps_to_fs_t;

endpackage

// File: rtl/fetch_request.sv
`timescale 1ns/1ps

module fetch_request (
    input  logic                        clk,
    input  logic                        reset,
    input  mips_cp0_pkg::vaddr_t        nextpc,
    input  logic                        flush,
    input  logic                        br_flush,
    input  logic                        fs_allowin,
    input  logic                        icache_busy,
    input  logic                        cache_inst_strobe,
    input  mips_cp0_pkg::cache_index_t  cache_index,
    input  mips_cp0_pkg::pfn_t          pfn,
    input  logic                        tlb_ex,
    input  mips_cp0_pkg::exc_code_t     tlb_exctype,
    input  logic                        tlb_stall,
    output mips_cp0_pkg::vaddr_t        pc,
    output fetch_bus_pkg::icache_req_t  icache_req,
    output fetch_bus_pkg::ps_to_fs_t    ps_to_fs
);
    import mips_cp0_pkg::*;

    logic         fetch_en;
    logic         ready;
    logic         allowin;
    logic         adel_ex;
    logic         ps_ex;
    exc_code_t    ps_exctype;
    logic         inst_valid;
    logic         flush_delayed;
    logic         cache_inst_delayed;
    cache_index_t cache_index_delayed;

    assign ready   = ~icache_busy & ~tlb_stall;
    assign allowin = flush | (fs_allowin & ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (flush | (~icache_busy & allowin)) begin
            pc <= nextpc;
        end
    end

    // fetch starts only once reset has been seen low at an edge
    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    // address error wins over the tlb
    assign adel_ex    = pc[1:0] != 2'b00;
    assign ps_ex      = (adel_ex | tlb_ex) & ~br_flush;
    assign ps_exctype = br_flush ? EXC_NONE :
                        adel_ex  ? EXC_ADEL :
                        tlb_ex   ? tlb_exctype :
                                   EXC_NONE;

    // remember a flush while the cache is still busy
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_delayed <= 1'b0;
        end else if (flush) begin
            flush_delayed <= 1'b1;
        end else if (~icache_busy) begin
            flush_delayed <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cache_inst_delayed <= 1'b0;
        end else if (cache_inst_strobe) begin
            cache_inst_delayed <= 1'b1;
        end else if (~icache_busy) begin
            cache_inst_delayed <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cache_inst_strobe) begin
            cache_index_delayed <= cache_index;
        end
    end

    always_comb begin
        if (~fetch_en | ps_ex | tlb_stall | br_flush) begin
            inst_valid = 1'b0;
        end else if (flush_delayed & ~icache_busy) begin
            inst_valid = 1'b1;
        end else begin
            inst_valid = ~icache_busy & allowin;
        end
    end

    // cache-op index overrides the pc until the cache is done
    assign icache_req.index  = cache_inst_delayed ? cache_index_delayed : pc[11:4];
    assign icache_req.tag    = pfn;
    assign icache_req.offset = pc[3:0];
    assign icache_req.valid  = fetch_en & ~ps_ex & ~tlb_stall &
                               (flush | (~icache_busy & fs_allowin));

    assign ps_to_fs.inst_valid = inst_valid;
    assign ps_to_fs.pc         = pc;
    assign ps_to_fs.ex         = ps_ex;
    assign ps_to_fs.exctype    = ps_exctype;

endmodule

// File: rtl/itlb_translate.sv
`timescale 1ns/1ps

module itlb_translate (
    input  logic                     clk,
    input  logic                     reset,
    input  mips_cp0_pkg::vpn_t       vpn,
    input  logic                     tlb_flush,
    output mips_cp0_pkg::vpn_t       tlb_vpn,
    input  fetch_bus_pkg::tlb_resp_t tlb_resp,
    output mips_cp0_pkg::pfn_t       pfn,
    output logic                     tlb_ex,
    output mips_cp0_pkg::exc_code_t  tlb_exctype,
    output logic                     tlb_stall
);
    import mips_cp0_pkg::*;
    import fetch_bus_pkg::*;

    // FILL is the first cycle after a refill, VALID a reused entry
    typedef enum logic [1:0] {
        TB_EMPTY,
        TB_FILL,
        TB_VALID
    } tb_state_t;

    tb_state_t  state;
    tb_state_t  next_state;
    vpn_t       buf_vpn;
    tlb_resp_t  buf_resp;
    tlb_entry_t buf_page;
    vaddr_t     page_addr;
    logic       unmapped;
    logic       hit;
    logic       refill;

    assign page_addr = {vpn, 12'h000};
    assign unmapped  = (page_addr >= KSEG0_BASE) && (page_addr < KSEG2_BASE);

    assign hit    = (state != TB_EMPTY) && (buf_vpn == vpn);
    assign refill = ~unmapped & ~hit;

    // main TLB is looked up every cycle, its answer only matters on refill
    assign tlb_vpn = vpn;

    always_comb begin
        next_state = state;
        if (tlb_flush) begin
            next_state = TB_EMPTY;
        end else if (refill) begin
            next_state = TB_FILL;
        end else if (state == TB_FILL) begin
            next_state = TB_VALID;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= TB_EMPTY;
        end else begin
            state <= next_state;
        end
    end

    // buffer contents, written only when a refill is in progress
    always_ff @(posedge clk) begin
        if (refill) begin
            buf_vpn  <= vpn;
            buf_resp <= tlb_resp;
            buf_page <= vpn[0] ? tlb_resp.odd : tlb_resp.even;
        end
    end

    // kseg0/kseg1 frame is the vpn with the segment bits cleared
    assign pfn = unmapped ? {3'b000, vpn[16:0]} : buf_page.pfn;

    assign tlb_stall = refill;

    // miss or invalid page, reported once the entry is buffered
    assign tlb_ex      = ~unmapped & hit & (~buf_resp.found | ~buf_page.v);
    assign tlb_exctype = tlb_ex ? EXC_TLBL : EXC_NONE;

endmodule

// File: rtl/mips_cp0_pkg.sv
package mips_cp0_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] pfn_t;

    // set index, address bits 11 to 4
    typedef logic [7:0] cache_index_t;

    typedef logic [4:0] exc_code_t;

    // CP0 cause codes used by instruction fetch
    localparam exc_code_t EXC_NONE = 5'd31;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_TLBL = 5'd2;

    // boot vector in kseg1
    localparam vaddr_t RESET_PC = 32'hBFC0_0000;

    // kseg0 and kseg1 are unmapped, kseg2 starts the mapped region again
    localparam vaddr_t KSEG0_BASE = 32'h8000_0000;
    localparam vaddr_t KSEG2_BASE = 32'hC000_0000;

endpackage

// File: rtl/next_pc_decode.sv
`timescale 1ns/1ps

module next_pc_decode (
    input  mips_cp0_pkg::vaddr_t   pc,
    input  fetch_bus_pkg::bpu_bus_t bpu,
    input  fetch_bus_pkg::br_bus_t  br,
    input  logic                   flush,
    input  logic                   eret,
    input  logic                   refetch,
    input  mips_cp0_pkg::vaddr_t   exc_addr,
    input  mips_cp0_pkg::vaddr_t   epc,
    input  mips_cp0_pkg::vaddr_t   refetch_pc,
    output mips_cp0_pkg::vaddr_t   nextpc
);
    import mips_cp0_pkg::*;

    vaddr_t seq_pc;
    vaddr_t slot_pc;
    vaddr_t right_flow_pc;
    vaddr_t wrong_flow_pc;
    vaddr_t flush_pc;
    logic   mispredict;
    logic   unpredicted_taken;

    assign seq_pc  = pc + 32'd4;

    // fall-through past the delay slot
    assign slot_pc = br.br_es_pc + 32'd8;

    // predictor path when execute has nothing to correct
    assign right_flow_pc = bpu.valid ? bpu.target : seq_pc;

    // recovery target after a wrong prediction
    assign wrong_flow_pc = br.br_taken ? br.br_target : slot_pc;

    assign flush_pc = refetch ? refetch_pc : exc_addr;

    assign mispredict        = br.is_branch & br.br_bpu_valid & ~br.br_bpu_right;
    assign unpredicted_taken = br.is_branch & ~br.br_bpu_valid & br.br_taken;

    always_comb begin
        if (eret) begin
            nextpc = epc;
        end else if (flush) begin
            nextpc = flush_pc;
        end else if (mispredict) begin
            nextpc = wrong_flow_pc;
        end else if (unpredicted_taken) begin
            nextpc = br.br_target;
        end else begin
            nextpc = right_flow_pc;
        end
    end

endmodule

// File: rtl/pre_if_top.sv
`timescale 1ns/1ps

module pre_if_top (
    input  logic                       clk,
    input  logic                       reset,
    input  fetch_bus_pkg::bpu_bus_t    bpu,
    input  fetch_bus_pkg::br_bus_t     br,
    input  logic                       flush,
    input  logic                       br_flush,
    input  logic                       eret,
    input  logic                       refetch,
    input  mips_cp0_pkg::vaddr_t       exc_addr,
    input  mips_cp0_pkg::vaddr_t       epc,
    input  mips_cp0_pkg::vaddr_t       refetch_pc,
    input  logic                       fs_allowin,
    input  logic                       icache_busy,
    input  logic                       tlb_flush,
    input  logic                       cache_inst_strobe,
    input  mips_cp0_pkg::cache_index_t cache_index,
    output mips_cp0_pkg::vpn_t         tlb_vpn,
    input  fetch_bus_pkg::tlb_resp_t   tlb_resp,
    output fetch_bus_pkg::icache_req_t icache_req,
    output fetch_bus_pkg::ps_to_fs_t   ps_to_fs,
    output mips_cp0_pkg::vaddr_t       prefs_pc
);
    import mips_cp0_pkg::*;

    vaddr_t    nextpc;
    pfn_t      pfn;
    logic      tlb_ex;
    exc_code_t tlb_exctype;
    logic      tlb_stall;

    next_pc_decode u_next_pc (
        .pc         (prefs_pc),
        .bpu        (bpu),
        .br         (br),
        .flush      (flush),
        .eret       (eret),
        .refetch    (refetch),
        .exc_addr   (exc_addr),
        .epc        (epc),
        .refetch_pc (refetch_pc),
        .nextpc     (nextpc)
    );

    // page number of the pc being fetched
    itlb_translate u_itlb (
        .clk         (clk),
        .reset       (reset),
        .vpn         (prefs_pc[31:12]),
        .tlb_flush   (tlb_flush),
        .tlb_vpn     (tlb_vpn),
        .tlb_resp    (tlb_resp),
        .pfn         (pfn),
        .tlb_ex      (tlb_ex),
        .tlb_exctype (tlb_exctype),
        .tlb_stall   (tlb_stall)
    );

    fetch_request u_fetch_req (
        .clk               (clk),
        .reset             (reset),
        .nextpc            (nextpc),
        .flush             (flush),
        .br_flush          (br_flush),
        .fs_allowin        (fs_allowin),
        .icache_busy       (icache_busy),
        .cache_inst_strobe (cache_inst_strobe),
        .cache_index       (cache_index),
        .pfn               (pfn),
        .tlb_ex            (tlb_ex),
        .tlb_exctype       (tlb_exctype),
        .tlb_stall         (tlb_stall),
        .pc                (prefs_pc),
        .icache_req        (icache_req),
        .ps_to_fs          (ps_to_fs)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the pre-fetch stage testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pre_if_tb \
    -f pre_if_front.f -o pre_if_sim \
    && ./obj_dir/pre_if_sim | grep -q -F '*** PASSED ***' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
